// File: rename_top.f
logic/rv_isa_pkg.sv
logic/rename_pkg.sv
logic/decode_stage.sv
logic/rename_table.sv
logic/bypass_stage.sv
logic/rename_top.sv
bench/rename_properties.sv
bench/rename_checker.sv
bench/tb_rename_top.sv

// File: Bender.yml
package:
  name: rename_top

sources:
  - logic/rv_isa_pkg.sv
  - logic/rename_pkg.sv
  - logic/decode_stage.sv
  - logic/rename_table.sv
  - logic/bypass_stage.sv
  - logic/rename_top.sv
  - target: test
    files:
      - bench/rename_properties.sv
      - bench/rename_checker.sv
      - bench/tb_rename_top.sv

// File: bench/tb_rename_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename_top
    import rv_isa_pkg::*;
();

    localparam int ISSUE_WIDTH     = 2;
    localparam int RETIRE_WIDTH    = 2;
    localparam int ROB_TAG_W       = 6;
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = 2 + 3 + 6 + 7 + 10 + 4;  // reset, then five sequences
    localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 20;
    localparam logic [6:0] OP_ALU  = 7'b0110011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;

    logic                                   clk;
    logic                                   rst;
    logic [ISSUE_WIDTH-1:0]                 issue_valid;
    logic [ISSUE_WIDTH-1:0][INSTR_W-1:0]    issue_instr;
    logic [ROB_TAG_W-1:0]                   rob_tail;
    logic                                   rob_full;
    logic [RETIRE_WIDTH-1:0]                retire_valid;
    logic [RETIRE_WIDTH-1:0][REG_ADDR_W-1:0] retire_rd;
    logic [RETIRE_WIDTH-1:0][ROB_TAG_W-1:0] retire_tag;
    logic [ISSUE_WIDTH-1:0]                 ren_valid;
    logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]  ren_tag;
    logic [ISSUE_WIDTH-1:0][1:0][ROB_TAG_W-1:0] src_index;
    logic [ISSUE_WIDTH-1:0][1:0]            src_in_rf;
    logic [8*32-1:0]                        test_name;
    int                                     checker_errors;
    int                                     cycle_count;
    integer                                 seed;
    logic [ROB_TAG_W-1:0]                   tail_track;  // next free tag in random mode

    rename_top #(.ISSUE_WIDTH(ISSUE_WIDTH), .RETIRE_WIDTH(RETIRE_WIDTH),
                 .ROB_TAG_W(ROB_TAG_W)) i_rename_top (
        .clk, .rst, .issue_valid, .issue_instr, .rob_tail, .rob_full,
        .retire_valid, .retire_rd, .retire_tag, .ren_valid, .ren_tag, .src_index, .src_in_rf
    );

    rename_checker #(.ISSUE_WIDTH(ISSUE_WIDTH), .RETIRE_WIDTH(RETIRE_WIDTH),
                     .ROB_TAG_W(ROB_TAG_W)) i_rename_checker (
        .clk, .rst, .issue_valid, .issue_instr, .rob_tail, .rob_full,
        .retire_valid, .retire_rd, .retire_tag, .ren_valid, .ren_tag, .src_index, .src_in_rf,
        .test_name, .error_count(checker_errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [INSTR_W-1:0] encode(input logic [6:0] op, input logic [4:0] rd,
                                                  input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, op};
    endfunction

    task automatic set_slot(input int slot, input logic [INSTR_W-1:0] instr);
        issue_valid[slot] = 1'b1;
        issue_instr[slot] = instr;
    endtask

    task automatic set_retire(input int port, input logic [4:0] rd,
                              input logic [ROB_TAG_W-1:0] tag);
        retire_valid[port] = 1'b1;
        retire_rd[port]    = rd;
        retire_tag[port]   = tag;
    endtask

    // strobes last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #2;
        issue_valid  = '0;
        rob_full     = 1'b0;
        retire_valid = '0;
    endtask

    task automatic drain(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    function automatic logic [4:0] random_reg();
        if (($random(seed) & 7) == 0) begin
            return 5'($random(seed) & 31);
        end
        return 5'($random(seed) & 7);  // mostly low regs for more hits
    endfunction

    function automatic logic [INSTR_W-1:0] random_instr();
        logic [6:0] op;
        case ($random(seed) & 3)
            0:       op = OP_ALU;
            1:       op = OP_LOAD;
            2:       op = OPCODE_STORE;
            default: op = OPCODE_BRANCH;
        endcase
        return encode(op, random_reg(), random_reg(), random_reg());
    endfunction

    task automatic random_cycle();
        int                   accepted;
        logic [ROB_TAG_W-1:0] tag0;
        logic [ROB_TAG_W-1:0] tag1;
        accepted = 0;
        rob_tail = tail_track;
        rob_full = (($random(seed) & 7) == 0);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if ($random(seed) & 1) begin
                set_slot(i, random_instr());
                accepted += rob_full ? 0 : 1;
            end
        end
        tag0 = tail_track - 1 - ($random(seed) & 7);  // a few tags behind the tail
        tag1 = tag0 - 1 - ($random(seed) & 3);        // never equal to tag0
        if ($random(seed) & 1) begin
            set_retire(0, random_reg(), tag0);
        end
        if ($random(seed) & 1) begin
            set_retire(1, random_reg(), tag1);
        end
        next_cycle();
        tail_track = tail_track + ROB_TAG_W'(accepted);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        issue_valid  = '0;
        issue_instr  = '0;
        rob_tail     = '0;
        rob_full     = 1'b0;
        retire_valid = '0;
        retire_rd    = '0;
        retire_tag   = '0;
        cycle_count  = 0;
        seed         = 32'h4549;
        tail_track   = '0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        test_name = "reset identity";
        set_slot(0, encode(OPCODE_STORE, 5'd0, 5'd5, 5'd6));
        set_slot(1, encode(OP_ALU, 5'd0, 5'd7, 5'd31));
        next_cycle();
        drain(2);

        test_name = "rename then read";
        rob_tail = 6'd10;
        set_slot(0, encode(OP_ALU, 5'd5, 5'd1, 5'd2));
        next_cycle();
        rob_tail = 6'd11;
        set_slot(0, encode(OPCODE_STORE, 5'd6, 5'd5, 5'd3));  // rd field holds imm bits
        set_slot(1, encode(OPCODE_BRANCH, 5'd7, 5'd5, 5'd4));
        next_cycle();
        rob_tail = 6'd13;
        set_slot(0, encode(OP_ALU, 5'd0, 5'd6, 5'd7));
        set_slot(1, encode(OP_LOAD, 5'd2, 5'd0, 5'd5));
        next_cycle();
        drain(3);

        test_name = "bundle forwarding";
        rob_tail = 6'd20;
        set_slot(0, encode(OP_ALU, 5'd8, 5'd1, 5'd2));
        set_slot(1, encode(OP_ALU, 5'd3, 5'd8, 5'd8));
        next_cycle();
        rob_tail = 6'd22;
        set_slot(0, encode(OP_ALU, 5'd9, 5'd8, 5'd3));
        set_slot(1, encode(OP_LOAD, 5'd9, 5'd9, 5'd0));
        next_cycle();
        rob_tail = 6'd24;
        set_slot(1, encode(OP_ALU, 5'd4, 5'd9, 5'd3));  // slot 0 idle, slot 1 gets 24
        next_cycle();
        rob_tail = 6'd25;
        set_slot(0, encode(OP_ALU, 5'd0, 5'd4, 5'd9));
        next_cycle();
        drain(3);

        test_name = "retire override";
        rob_tail = 6'd40;
        set_slot(0, encode(OP_ALU, 5'd10, 5'd1, 5'd1));
        next_cycle();
        rob_tail = 6'd41;
        set_slot(0, encode(OP_ALU, 5'd0, 5'd10, 5'd5));
        next_cycle();
        set_retire(0, 5'd10, 6'd40);  // retires during the reader's lookup
        set_retire(1, 5'd5, 6'd10);
        next_cycle();
        rob_tail = 6'd42;
        set_slot(0, encode(OP_ALU, 5'd11, 5'd0, 5'd0));
        next_cycle();
        rob_tail = 6'd43;
        set_slot(0, encode(OP_ALU, 5'd11, 5'd0, 5'd0));
        next_cycle();
        next_cycle();
        set_retire(0, 5'd11, 6'd42);  // stale, x11 now names 43
        next_cycle();
        rob_tail = 6'd44;
        set_slot(0, encode(OP_ALU, 5'd0, 5'd11, 5'd10));
        next_cycle();
        drain(2);

        test_name = "rob full";
        rob_full = 1'b1;
        rob_tail = 6'd45;
        set_slot(0, encode(OP_ALU, 5'd12, 5'd1, 5'd2));
        set_slot(1, encode(OP_ALU, 5'd13, 5'd12, 5'd3));
        next_cycle();
        set_slot(0, encode(OP_ALU, 5'd0, 5'd12, 5'd13));
        next_cycle();
        drain(2);

        test_name  = "random";
        tail_track = 6'd46;
        repeat (RANDOM_CYCLES) random_cycle();
        drain(3);

        $display("closing: %0d value mismatches, %0d assertion failures",
                 checker_errors, i_rename_top.i_rename_properties.fail_count);
        if (checker_errors == 0 && i_rename_top.i_rename_properties.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rename_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rename_checker
    import rv_isa_pkg::*;
    import rename_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int RETIRE_WIDTH = 2,
    parameter int ROB_TAG_W    = 6
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [ISSUE_WIDTH-1:0]                              issue_valid,
    input  logic [ISSUE_WIDTH-1:0][INSTR_W-1:0]                 issue_instr,
    input  logic [ROB_TAG_W-1:0]                                rob_tail,
    input  logic                                                rob_full,
    input  logic [RETIRE_WIDTH-1:0]                             retire_valid,
    input  logic [RETIRE_WIDTH-1:0][REG_ADDR_W-1:0]             retire_rd,
    input  logic [RETIRE_WIDTH-1:0][ROB_TAG_W-1:0]              retire_tag,
    input  logic [ISSUE_WIDTH-1:0]                              ren_valid,
    input  logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               ren_tag,
    input  logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] src_index,
    input  logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                src_in_rf,
    input  logic [8*32-1:0]                                     test_name,
    output int                                                  error_count
);

    logic                  tbl_in_rf [ARCH_REGS];   // model alias table
    logic [ROB_TAG_W-1:0]  tbl_index [ARCH_REGS];
    // stage 0 is the accepted bundle, stage 1 the expected outputs
    logic                  s0_valid  [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0] s0_rs1    [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0] s0_rs2    [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0] s0_rd     [ISSUE_WIDTH];
    logic                  s0_wr     [ISSUE_WIDTH];
    logic [ROB_TAG_W-1:0]  s0_tag    [ISSUE_WIDTH];
    logic                  ex_valid  [ISSUE_WIDTH];
    logic [ROB_TAG_W-1:0]  ex_tag    [ISSUE_WIDTH];
    logic                  ex_in_rf  [ISSUE_WIDTH][NUM_SRCS];
    logic [ROB_TAG_W-1:0]  ex_index  [ISSUE_WIDTH][NUM_SRCS];
    logic                  model_ready = 1'b0;      // set by the first reset
    int                    mismatches  = 0;

    assign error_count = mismatches;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // lookup, retire override, then earlier writers in the bundle
    function automatic logic [ROB_TAG_W:0] expect_source(input int slot,
                                                          input logic [REG_ADDR_W-1:0] src);
        logic                 kind;
        logic [ROB_TAG_W-1:0] idx;
        kind = tbl_in_rf[src];
        idx  = tbl_index[src];
        for (int r = 0; r < RETIRE_WIDTH; r++) begin
            if (tbl_in_rf[src] == SRC_IN_ROB && retire_valid[r]
                    && retire_tag[r] == tbl_index[src]) begin
                kind = SRC_IN_RF;
                idx  = ROB_TAG_W'(retire_rd[r]);
            end
        end
        for (int j = 0; j < slot; j++) begin
            if (s0_wr[j] && s0_rd[j] == src) begin
                kind = SRC_IN_ROB;  // latest earlier writer wins
                idx  = s0_tag[j];
            end
        end
        return {kind, idx};
    endfunction

    task automatic reset_model();
        for (int e = 0; e < ARCH_REGS; e++) begin
            tbl_in_rf[e] = SRC_IN_RF;
            tbl_index[e] = ROB_TAG_W'(e);
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            s0_valid[i] = 1'b0;
            s0_wr[i]    = 1'b0;
            ex_valid[i] = 1'b0;
        end
        model_ready = 1'b1;
    endtask

    task automatic update_table();
        logic claimed [ARCH_REGS];
        for (int e = 0; e < ARCH_REGS; e++) begin
            claimed[e] = 1'b0;
        end
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin  // highest slot claims first
            if (s0_wr[i] && !claimed[s0_rd[i]]) begin
                tbl_in_rf[s0_rd[i]] = SRC_IN_ROB;
                tbl_index[s0_rd[i]] = s0_tag[i];
                claimed[s0_rd[i]]   = 1'b1;
            end
        end
        // free only entries that still name the retiring tag
        for (int r = 0; r < RETIRE_WIDTH; r++) begin
            if (retire_valid[r] && !claimed[retire_rd[r]]
                    && tbl_in_rf[retire_rd[r]] == SRC_IN_ROB
                    && tbl_index[retire_rd[r]] == retire_tag[r]) begin
                tbl_in_rf[retire_rd[r]] = SRC_IN_RF;
                tbl_index[retire_rd[r]] = ROB_TAG_W'(retire_rd[r]);
            end
        end
    endtask

    task automatic load_stage0();
        logic [ROB_TAG_W-1:0] next_tag;
        logic [6:0]           op;
        next_tag = rob_tail;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            op          = issue_instr[i][6:0];
            s0_valid[i] = issue_valid[i] && !rob_full;
            s0_rs1[i]   = issue_instr[i][19:15];
            s0_rs2[i]   = issue_instr[i][24:20];
            s0_rd[i]    = issue_instr[i][11:7];
            s0_wr[i]    = s0_valid[i] && op != OPCODE_STORE && op != OPCODE_BRANCH
                          && s0_rd[i] != '0;
            s0_tag[i]   = next_tag;
            if (s0_valid[i]) begin
                next_tag = next_tag + 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                ex_valid[i] = s0_valid[i];
                ex_tag[i]   = s0_tag[i];
                {ex_in_rf[i][SRC_RS1], ex_index[i][SRC_RS1]} = expect_source(i, s0_rs1[i]);
                {ex_in_rf[i][SRC_RS2], ex_index[i][SRC_RS2]} = expect_source(i, s0_rs2[i]);
            end
            update_table();
            load_stage0();
        end
    end

    //////////////////////////////////////////////////
    // comparison
    //////////////////////////////////////////////////

    task automatic check_value(input string field, input int slot,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("ERROR %0s: %0s slot %0d expected %0h actual %0h at %0t",
                     test_name, field, slot, expected, actual, $time);
        end
    endtask

    // outputs settle after the rising edge, compare mid-cycle
    always @(negedge clk) begin
        if (model_ready) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                check_value("ren_valid", i, ex_valid[i], ren_valid[i]);
                if (ex_valid[i]) begin
                    check_value("ren_tag", i, ex_tag[i], ren_tag[i]);
                    for (int s = 0; s < NUM_SRCS; s++) begin
                        check_value((s == SRC_RS1) ? "src_in_rf rs1" : "src_in_rf rs2", i,
                                    ex_in_rf[i][s], src_in_rf[i][s]);
                        check_value((s == SRC_RS1) ? "src_index rs1" : "src_index rs2", i,
                                    ex_index[i][s], src_index[i][s]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/rename_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rename_properties #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ISSUE_WIDTH-1:0] issue_valid,
    input  logic                   rob_full,
    input  logic [ISSUE_WIDTH-1:0] ren_valid
);

    int                     fail_count = 0;  // read by the testbench at the end
    logic [ISSUE_WIDTH-1:0] accepted;

    assign accepted = issue_valid & {ISSUE_WIDTH{~rob_full}};

    valid_clear_after_reset: assert property (@(posedge clk) rst |=> (ren_valid == '0))
        else begin
            fail_count++;
            $error("ren_valid high in the cycle after reset");
        end

    // two register stages between issue and output
    valid_follows_issue: assert property (@(posedge clk)
        (!$past(rst, 1) && !$past(rst, 2)) |-> (ren_valid == $past(accepted, 2)))
        else begin
            fail_count++;
            $error("ren_valid does not follow the accepted issue_valid");
        end

    no_valid_when_full: assert property (@(posedge clk) $past(rob_full, 2) |-> (ren_valid == '0))
        else begin
            fail_count++;
            $error("slot valid although rob_full was high at its sampling edge");
        end

endmodule

bind rename_top rename_properties #(.ISSUE_WIDTH(ISSUE_WIDTH)) i_rename_properties (
    .clk, .rst, .issue_valid, .rob_full, .ren_valid
);

`default_nettype wire

// File: logic/rename_top.sv
`timescale 1ns/100ps
`default_nettype none

module rename_top
    import rv_isa_pkg::*;
    import rename_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int RETIRE_WIDTH = 2,
    parameter int ROB_TAG_W    = 6   // at least REG_ADDR_W
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [ISSUE_WIDTH-1:0]                              issue_valid,
    input  logic [ISSUE_WIDTH-1:0][INSTR_W-1:0]                 issue_instr,
    input  logic [ROB_TAG_W-1:0]                                rob_tail,
    input  logic                                                rob_full,
    input  logic [RETIRE_WIDTH-1:0]                             retire_valid,
    input  logic [RETIRE_WIDTH-1:0][REG_ADDR_W-1:0]             retire_rd,
    input  logic [RETIRE_WIDTH-1:0][ROB_TAG_W-1:0]              retire_tag,
    output logic [ISSUE_WIDTH-1:0]                              ren_valid,
    output logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               ren_tag,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] src_index,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                src_in_rf
);

    // decode to table and bypass
    logic [ISSUE_WIDTH-1:0]                              dc_valid;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rs1;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rs2;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rd;
    logic [ISSUE_WIDTH-1:0]                              dc_writes_rd;
    logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               dc_tag;
    // table read results
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                rd_in_rf;
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] rd_index;

    decode_stage #(.ISSUE_WIDTH(ISSUE_WIDTH), .ROB_TAG_W(ROB_TAG_W)) i_decode_stage (
        .clk, .rst, .issue_valid, .issue_instr, .rob_tail, .rob_full,
        .dc_valid, .dc_rs1, .dc_rs2, .dc_rd, .dc_writes_rd, .dc_tag
    );

    rename_table #(.ISSUE_WIDTH(ISSUE_WIDTH), .RETIRE_WIDTH(RETIRE_WIDTH),
                   .ROB_TAG_W(ROB_TAG_W)) i_rename_table (
        .clk, .rst, .dc_rs1, .dc_rs2, .dc_rd, .dc_writes_rd, .dc_tag,
        .retire_valid, .retire_rd, .retire_tag, .rd_in_rf, .rd_index
    );

    bypass_stage #(.ISSUE_WIDTH(ISSUE_WIDTH), .RETIRE_WIDTH(RETIRE_WIDTH),
                   .ROB_TAG_W(ROB_TAG_W)) i_bypass_stage (
        .clk, .rst, .dc_valid, .dc_rs1, .dc_rs2, .dc_rd, .dc_writes_rd, .dc_tag,
        .rd_in_rf, .rd_index, .retire_valid, .retire_rd, .retire_tag,
        .ren_valid, .ren_tag, .src_index, .src_in_rf
    );

endmodule

`default_nettype wire

// File: logic/bypass_stage.sv
`timescale 1ns/100ps
`default_nettype none

module bypass_stage
    import rename_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int RETIRE_WIDTH = 2,
    parameter int ROB_TAG_W    = 6
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [ISSUE_WIDTH-1:0]                              dc_valid,
    input  logic [ISSUE_WIDTH-1:0][$clog2(ARCH_REGS)-1:0]       dc_rs1,
    input  logic [ISSUE_WIDTH-1:0][$clog2(ARCH_REGS)-1:0]       dc_rs2,
    input  logic [ISSUE_WIDTH-1:0][$clog2(ARCH_REGS)-1:0]       dc_rd,
    input  logic [ISSUE_WIDTH-1:0]                              dc_writes_rd,
    input  logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               dc_tag,
    input  logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                rd_in_rf,
    input  logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] rd_index,
    input  logic [RETIRE_WIDTH-1:0]                             retire_valid,
    input  logic [RETIRE_WIDTH-1:0][$clog2(ARCH_REGS)-1:0]      retire_rd,
    input  logic [RETIRE_WIDTH-1:0][ROB_TAG_W-1:0]              retire_tag,
    output logic [ISSUE_WIDTH-1:0]                              ren_valid,
    output logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               ren_tag,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] src_index,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                src_in_rf
);

    localparam int RA_W = $clog2(ARCH_REGS);

    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][RA_W-1:0]         src_reg;
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][RETIRE_WIDTH-1:0] ret_hit;  // source x retire port
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ISSUE_WIDTH-1:0]  dep_hit;  // source x earlier slot
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                   fin_in_rf;
    logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0]    fin_index;

    ///////////////////////////////////////////////////
    // match matrices
    ///////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            src_reg[i][SRC_RS1] = dc_rs1[i];
            src_reg[i][SRC_RS2] = dc_rs2[i];
            for (int s = 0; s < NUM_SRCS; s++) begin
                for (int r = 0; r < RETIRE_WIDTH; r++) begin
                    ret_hit[i][s][r] = retire_valid[r]
                                     && (rd_in_rf[i][s] == SRC_IN_ROB)
                                     && (rd_index[i][s] == retire_tag[r]);
                end
                for (int j = 0; j < ISSUE_WIDTH; j++) begin
                    // only slots ahead of i count
                    dep_hit[i][s][j] = (j < i) && dc_writes_rd[j] && (dc_rd[j] == src_reg[i][s]);
                end
            end
        end
    end

    // retire override, then the latest earlier writer in the bundle
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                fin_in_rf[i][s] = rd_in_rf[i][s];
                fin_index[i][s] = rd_index[i][s];
                for (int r = 0; r < RETIRE_WIDTH; r++) begin
                    if (ret_hit[i][s][r]) begin
                        fin_in_rf[i][s] = SRC_IN_RF;
                        fin_index[i][s] = ROB_TAG_W'(retire_rd[r]);
                    end
                end
                for (int j = 0; j < ISSUE_WIDTH; j++) begin
                    if (dep_hit[i][s][j]) begin
                        fin_in_rf[i][s] = SRC_IN_ROB;
                        fin_index[i][s] = dc_tag[j];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= '0;
        end else begin
            ren_valid <= dc_valid;
        end
    end

    always_ff @(posedge clk) begin
        ren_tag   <= dc_tag;
        src_index <= fin_index;
        src_in_rf <= fin_in_rf;
    end

endmodule

`default_nettype wire

// File: logic/rename_table.sv
`timescale 1ns/100ps
`default_nettype none

module rename_table
    import rv_isa_pkg::*;
    import rename_pkg::*;
#(
    parameter int ISSUE_WIDTH  = 2,
    parameter int RETIRE_WIDTH = 2,
    parameter int ROB_TAG_W    = 6
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rs1,
    input  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rs2,
    input  logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0]              dc_rd,
    input  logic [ISSUE_WIDTH-1:0]                              dc_writes_rd,
    input  logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]               dc_tag,
    input  logic [RETIRE_WIDTH-1:0]                             retire_valid,
    input  logic [RETIRE_WIDTH-1:0][REG_ADDR_W-1:0]             retire_rd,
    input  logic [RETIRE_WIDTH-1:0][ROB_TAG_W-1:0]              retire_tag,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]                rd_in_rf,
    output logic [ISSUE_WIDTH-1:0][NUM_SRCS-1:0][ROB_TAG_W-1:0] rd_index
);

    ///////////////////////////////////////////////////
    // table storage
    ///////////////////////////////////////////////////

    logic [ARCH_REGS-1:0]                ent_in_rf;  // kind per entry
    logic [ARCH_REGS-1:0][ROB_TAG_W-1:0] ent_index;  // reg index or rob tag
    logic [ARCH_REGS-1:0]                nxt_in_rf;
    logic [ARCH_REGS-1:0][ROB_TAG_W-1:0] nxt_index;
    logic [RETIRE_WIDTH-1:0]             ret_free;   // retire still owns its entry

    // read ports, one pair per slot
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            rd_in_rf[i][SRC_RS1] = ent_in_rf[dc_rs1[i]];
            rd_index[i][SRC_RS1] = ent_index[dc_rs1[i]];
            rd_in_rf[i][SRC_RS2] = ent_in_rf[dc_rs2[i]];
            rd_index[i][SRC_RS2] = ent_index[dc_rs2[i]];
        end
    end

    ///////////////////////////////////////////////////
    // write arbitration
    ///////////////////////////////////////////////////

    // stale retirement must not undo a newer rename
    always_comb begin
        for (int r = 0; r < RETIRE_WIDTH; r++) begin
            ret_free[r] = retire_valid[r]
                        && (ent_in_rf[retire_rd[r]] == SRC_IN_ROB)
                        && (ent_index[retire_rd[r]] == retire_tag[r]);
        end
    end

    always_comb begin
        nxt_in_rf = ent_in_rf;
        nxt_index = ent_index;
        // retire first so any issue write lands on top
        for (int r = 0; r < RETIRE_WIDTH; r++) begin
            if (ret_free[r]) begin
                nxt_in_rf[retire_rd[r]] = SRC_IN_RF;
                nxt_index[retire_rd[r]] = ROB_TAG_W'(retire_rd[r]);
            end
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin  // higher slot wins
            if (dc_writes_rd[i]) begin
                nxt_in_rf[dc_rd[i]] = SRC_IN_ROB;
                nxt_index[dc_rd[i]] = dc_tag[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < ARCH_REGS; e++) begin
                ent_in_rf[e] <= SRC_IN_RF;        // identity mapping
                ent_index[e] <= ROB_TAG_W'(e);
            end
        end else begin
            ent_in_rf <= nxt_in_rf;
            ent_index <= nxt_index;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2,
    parameter int ROB_TAG_W   = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [ISSUE_WIDTH-1:0]                 issue_valid,
    input  logic [ISSUE_WIDTH-1:0][INSTR_W-1:0]    issue_instr,
    input  logic [ROB_TAG_W-1:0]                   rob_tail,
    input  logic                                   rob_full,
    output logic [ISSUE_WIDTH-1:0]                 dc_valid,
    output logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] dc_rs1,
    output logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] dc_rs2,
    output logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] dc_rd,
    output logic [ISSUE_WIDTH-1:0]                 dc_writes_rd,
    output logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]  dc_tag
);

    localparam int OP_W = $bits(OPCODE_STORE);

    logic [ISSUE_WIDTH-1:0]                 accept;     // valid and rob has room
    logic [ISSUE_WIDTH-1:0][OP_W-1:0]       opcode;
    logic [ISSUE_WIDTH-1:0]                 writes_rd;
    logic [ISSUE_WIDTH-1:0][ROB_TAG_W-1:0]  slot_tag;
    logic [ROB_TAG_W-1:0]                   tag_run;    // next free tag while walking slots

    assign accept = issue_valid & {ISSUE_WIDTH{~rob_full}};

    always_comb begin
        tag_run = rob_tail;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            opcode[i]    = issue_instr[i][OPCODE_LSB +: OP_W];
            // stores, branches and x0 keep their mapping
            writes_rd[i] = accept[i]
                         && (opcode[i] != OPCODE_STORE)
                         && (opcode[i] != OPCODE_BRANCH)
                         && (issue_instr[i][RD_LSB +: REG_ADDR_W] != '0);
            slot_tag[i]  = tag_run;
            if (accept[i]) begin
                tag_run = tag_run + 1'b1;  // wraps with the rob
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dc_valid     <= '0;
            dc_writes_rd <= '0;
        end else begin
            dc_valid     <= accept;
            dc_writes_rd <= writes_rd;
        end
    end

    // payload, loaded every cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            dc_rs1[i] <= issue_instr[i][RS1_LSB +: REG_ADDR_W];
            dc_rs2[i] <= issue_instr[i][RS2_LSB +: REG_ADDR_W];
            dc_rd[i]  <= issue_instr[i][RD_LSB +: REG_ADDR_W];
        end
        dc_tag <= slot_tag;
    end

endmodule

`default_nettype wire

// File: logic/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int ARCH_REGS = 32;  // alias table entries
    localparam int NUM_SRCS  = 2;

    // source slot indices
    localparam int SRC_RS1 = 0;
    localparam int SRC_RS2 = 1;

    // source kind, value lives in the register file or still in the rob
    localparam logic SRC_IN_RF  = 1'b1;
    localparam logic SRC_IN_ROB = 1'b0;

endpackage

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    ///////////////////////////////////////////////////
    // field positions
    ///////////////////////////////////////////////////

    // same spot in every format that renames
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    // formats without a destination
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;  // s-type
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;  // sb-type

endpackage

`default_nettype wire
